// ==== common/control_macros.svh ====
`ifndef CONTROL_MACROS_SVH
`define CONTROL_MACROS_SVH

`define OPCODE_W 6
`define FUNCT_W  6
`define STATE_W  5

`define OP_RTYPE 6'b000000
`define OP_J     6'b000010
`define OP_BEQ   6'b000100
`define OP_BNE   6'b000101
`define OP_ADDI  6'b001000
`define OP_ADDIU 6'b001001
`define OP_SLTI  6'b001010
`define OP_ANDI  6'b001100
`define OP_XORI  6'b001110
`define OP_LUI   6'b001111
`define OP_LW    6'b100011
`define OP_SW    6'b101011

`define FN_SLL   6'b000000
`define FN_SRL   6'b000010
`define FN_SRA   6'b000011
`define FN_SLLV  6'b000100
`define FN_SRAV  6'b000111
`define FN_JR    6'b001000
`define FN_BREAK 6'b001101
`define FN_ADD   6'b100000
`define FN_SUB   6'b100010
`define FN_AND   6'b100100
`define FN_XOR   6'b100110
`define FN_SLT   6'b101010

`endif

// ==== common/controlPkg.sv ====
`include "control_macros.svh"

package controlPkg;

	typedef enum logic [`STATE_W-1:0] {
		reset, fetch, fetchWait, irLoad, decode,
		rTypeLoad, aluExec, aluWriteback, shiftLoad, shiftExec,
		setLess, immExec, immWriteback, setLessImm, memAddr,
		loadWait, loadWriteback, storeWord, branch, jump,
		jumpReg, loadUpper, breakHalt, noOp, exception
	} state_t;

	typedef enum logic [4:0] {
		kindAdd, kindSub, kindAnd, kindXor, kindSlt,
		kindSll, kindSrl, kindSra, kindSllv, kindSrav,
		kindJr, kindBreak, kindUnknownFunct, // R-type group
		kindAddi, kindAddiu, kindAndi, kindSlti, kindXori,
		kindLw, kindSw, kindBeq, kindBne, kindJ,
		kindLui, kindIllegal
	} instrKind_t;

	typedef enum logic [1:0] {
		aluResult       = 2'b00,
		branchTarget    = 2'b01,
		jumpTarget      = 2'b10,
		exceptionVector = 2'b11
	} pcSrc_t;

	typedef enum logic [1:0] {
		regB       = 2'b00,
		constFour  = 2'b01,
		signImm    = 2'b10,
		shiftedImm = 2'b11 // Branch offset, shifted by two
	} aluSrcB_t;

	typedef enum logic [2:0] {
		pass  = 3'b000, // Operand A straight through
		add   = 3'b001,
		sub   = 3'b010,
		andOp = 3'b011,
		xorOp = 3'b110
	} aluOp_t;

	typedef enum logic [2:0] {
		aluOut   = 3'b000,
		mdr      = 3'b001,
		upperImm = 3'b010,
		shiftOut = 3'b101,
		lessThan = 3'b110
	} memToReg_t;

	typedef enum logic [2:0] {
		hold       = 3'b000,
		load       = 3'b001,
		left       = 3'b010,
		rightLogic = 3'b011,
		rightArith = 3'b100
	} shiftCtrl_t;

	typedef struct packed {
		pcSrc_t     pcSrc;
		logic       aluSrcA; // 0 PC, 1 register A
		aluSrcB_t   aluSrcB;
		aluOp_t     aluOp;
		logic       regWrite;
		logic       regDst; // 0 rt, 1 rd
		logic       irWrite;
		memToReg_t  memToReg;
		logic       memWrite;
		logic       mdrLoad;
		logic       iorD;
		logic       pcWrite;
		logic       pcWriteCond;
		logic       branchNe;
		logic       aluOutLoad;
		logic       aLoad;
		logic       bLoad;
		shiftCtrl_t shiftCtrl;
		logic       epcWrite;
	} ctrlWord_t;

endpackage

// ==== hdl/instrDecoder.sv ====
`include "control_macros.svh"

module instrDecoder import controlPkg::*; (
	input  logic [`OPCODE_W-1:0] opcode,
	input  logic [`FUNCT_W-1:0]  funct,
	output instrKind_t           kind
);

	instrKind_t rKind;

	// Funct table, only meaningful for R-type
	always_comb begin
		case (funct)
			`FN_ADD:   rKind = kindAdd;
			`FN_SUB:   rKind = kindSub;
			`FN_AND:   rKind = kindAnd;
			`FN_XOR:   rKind = kindXor;
			`FN_SLT:   rKind = kindSlt;
			`FN_SLL:   rKind = kindSll;
			`FN_SRL:   rKind = kindSrl;
			`FN_SRA:   rKind = kindSra;
			`FN_SLLV:  rKind = kindSllv;
			`FN_SRAV:  rKind = kindSrav;
			`FN_JR:    rKind = kindJr;
			`FN_BREAK: rKind = kindBreak;
			default:   rKind = kindUnknownFunct;
		endcase
	end

	always_comb begin
		case (opcode)
			`OP_RTYPE: begin
				kind = rKind;
			end
			`OP_ADDI: begin
				kind = kindAddi;
			end
			`OP_ADDIU: begin
				kind = kindAddiu;
			end
			`OP_ANDI: begin
				kind = kindAndi;
			end
			`OP_SLTI: begin
				kind = kindSlti;
			end
			`OP_XORI: begin
				kind = kindXori;
			end
			`OP_LW: begin
				kind = kindLw;
			end
			`OP_SW: begin
				kind = kindSw;
			end
			`OP_BEQ: begin
				kind = kindBeq;
			end
			`OP_BNE: begin
				kind = kindBne;
			end
			`OP_J: begin
				kind = kindJ;
			end
			`OP_LUI: begin
				kind = kindLui;
			end
			default: begin
				kind = kindIllegal; // Raises the opcode exception
			end
		endcase
	end

endmodule

// ==== hdl/controlSequencer.sv ====
module controlSequencer import controlPkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  instrKind_t kind,
	input  logic       overflow,
	output state_t     state,
	output instrKind_t heldKind
);

	state_t nextState;
	logic   arithTrap;
	logic   immTrap;

	// Only signed arithmetic traps on overflow
	assign arithTrap = overflow && (heldKind == kindAdd || heldKind == kindSub);
	assign immTrap   = overflow && (heldKind == kindAddi);

	always_ff @(posedge clock) begin
		if (reset) begin
			state    <= controlPkg::reset;
			heldKind <= kindIllegal;
		end else begin
			state <= nextState;
			if (state == decode) begin
				heldKind <= kind; // Instruction register is stable here
			end
		end
	end

	always_comb begin
		case (state)
			controlPkg::reset: nextState = fetch;
			fetch:             nextState = fetchWait;
			fetchWait:         nextState = irLoad;
			irLoad:            nextState = decode;
			decode: begin
				case (kind)
					kindAdd, kindSub, kindAnd, kindXor, kindSlt,
					kindSll, kindSrl, kindSra, kindSllv, kindSrav,
					kindJr, kindBreak, kindUnknownFunct: begin
						nextState = rTypeLoad;
					end
					kindAddi, kindAddiu, kindAndi, kindXori: begin
						nextState = immExec;
					end
					kindSlti:         nextState = setLessImm;
					kindLw, kindSw:   nextState = memAddr;
					kindBeq, kindBne: nextState = branch;
					kindJ:            nextState = jump;
					kindLui:          nextState = loadUpper;
					default:          nextState = exception;
				endcase
			end
			rTypeLoad: begin
				case (heldKind)
					kindAdd, kindSub, kindAnd, kindXor: nextState = aluExec;
					kindSlt:   nextState = setLess;
					kindSll, kindSrl, kindSra, kindSllv, kindSrav: begin
						nextState = shiftLoad;
					end
					kindJr:    nextState = jumpReg;
					kindBreak: nextState = breakHalt;
					default:   nextState = noOp;
				endcase
			end
			aluExec: begin
				nextState = arithTrap ? exception : aluWriteback;
			end
			immExec: begin
				nextState = immTrap ? exception : immWriteback;
			end
			shiftLoad: nextState = shiftExec;
			memAddr: begin
				nextState = (heldKind == kindSw) ? storeWord : loadWait;
			end
			loadWait:  nextState = loadWriteback;
			breakHalt: nextState = breakHalt; // Left only through reset
			default:   nextState = fetch;
		endcase
	end

	breakHeld: assert property (@(posedge clock)
		(state == breakHalt && !reset) |=> state == breakHalt)
		else $error("sequencer left breakHalt without a reset");

endmodule

// ==== hdl/controlEncoder.sv ====
module controlEncoder import controlPkg::*; (
	input  state_t     state,
	input  instrKind_t heldKind,
	output ctrlWord_t  ctrl
);

	// Shared by the register and immediate forms
	function automatic aluOp_t aluOpFor(input instrKind_t k);
		case (k)
			kindSub:            return sub;
			kindAnd, kindAndi:  return andOp;
			kindXor, kindXori:  return xorOp;
			default:            return add;
		endcase
	endfunction

	function automatic shiftCtrl_t shiftFor(input instrKind_t k);
		case (k)
			kindSll, kindSllv: return left;
			kindSrl:           return rightLogic;
			kindSra, kindSrav: return rightArith;
			default:           return hold;
		endcase
	endfunction

	always_comb begin
		ctrl = '0;
		case (state)
			fetch: begin
				ctrl.pcWrite = 1'b1;
				ctrl.aluSrcB = constFour;
				ctrl.aluOp   = add; // PC + 4
			end
			irLoad: begin
				ctrl.irWrite = 1'b1;
			end
			decode: begin
				ctrl.aluSrcB = shiftedImm;
			end
			rTypeLoad: begin
				ctrl.aLoad = 1'b1;
				ctrl.bLoad = 1'b1;
			end
			aluExec: begin
				ctrl.aluSrcA    = 1'b1;
				ctrl.aluOutLoad = 1'b1;
				ctrl.aluOp      = aluOpFor(heldKind);
			end
			aluWriteback: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst   = 1'b1;
				ctrl.memToReg = aluOut;
			end
			shiftLoad: begin
				ctrl.shiftCtrl = load;
			end
			shiftExec: begin
				ctrl.regWrite  = 1'b1;
				ctrl.regDst    = 1'b1;
				ctrl.memToReg  = shiftOut;
				ctrl.shiftCtrl = shiftFor(heldKind);
			end
			setLess, setLessImm: begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = lessThan;
				ctrl.aluOp    = sub; // Comparison comes from the ALU sign
				ctrl.regDst   = (state == setLess);
			end
			immExec: begin
				ctrl.aluSrcA    = 1'b1;
				ctrl.aluSrcB    = signImm;
				ctrl.aluOutLoad = 1'b1;
				ctrl.aluOp      = aluOpFor(heldKind);
			end
			immWriteback: begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = aluOut;
			end
			memAddr: begin
				ctrl.aluSrcA    = 1'b1;
				ctrl.aluSrcB    = signImm;
				ctrl.aluOp      = add;
				ctrl.aluOutLoad = 1'b1;
			end
			loadWait: begin
				ctrl.iorD    = 1'b1;
				ctrl.mdrLoad = 1'b1;
			end
			loadWriteback: begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = mdr;
			end
			storeWord: begin
				ctrl.iorD     = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			branch: begin
				ctrl.aluSrcA     = 1'b1;
				ctrl.aluOp       = sub;
				ctrl.pcWriteCond = 1'b1;
				ctrl.pcSrc       = branchTarget;
				ctrl.branchNe    = (heldKind == kindBne);
			end
			jump: begin
				ctrl.pcWrite = 1'b1;
				ctrl.pcSrc   = jumpTarget;
			end
			jumpReg: begin
				ctrl.aluSrcA = 1'b1;
				ctrl.aluOp   = pass;
				ctrl.pcWrite = 1'b1;
				ctrl.pcSrc   = aluResult;
			end
			loadUpper: begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = upperImm;
			end
			exception: begin
				ctrl.pcWrite  = 1'b1;
				ctrl.epcWrite = 1'b1;
				ctrl.pcSrc    = exceptionVector;
				ctrl.aluOp    = sub; // EPC gets PC - 4
				ctrl.aluSrcB  = constFour;
			end
			default: begin
				ctrl = '0;
			end
		endcase

		assert (!(ctrl.memWrite && ctrl.regWrite))
			else $error("memory and register write together in %s", state.name());
		assert (!(ctrl.pcWrite && ctrl.pcWriteCond))
			else $error("both PC write enables set in %s", state.name());
		assert (!ctrl.epcWrite || ctrl.pcSrc == exceptionVector)
			else $error("EPC written without the exception vector in %s", state.name());
	end

endmodule

// ==== hdl/unidadeControle.sv ====
`include "control_macros.svh"

module unidadeControle import controlPkg::*; (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 overflow,
	input  logic [`OPCODE_W-1:0] opcode,
	input  logic [`FUNCT_W-1:0]  funct,
	output ctrlWord_t            ctrl,
	output state_t               state
);

	instrKind_t kind;
	instrKind_t heldKind;

	instrDecoder instrDecoder_i (
		.opcode (opcode),
		.funct  (funct),
		.kind   (kind)
	);

	controlSequencer controlSequencer_i (
		.clock    (clock),
		.reset    (reset),
		.kind     (kind),
		.overflow (overflow),
		.state    (state),
		.heldKind (heldKind)
	);

	controlEncoder controlEncoder_i (
		.state    (state),
		.heldKind (heldKind),
		.ctrl     (ctrl)
	);

endmodule

// ==== verification/controlTests.svh ====
// Reference word, built field by field from the encoder table
function automatic ctrlWord_t expectedWord(input state_t s, input instrKind_t k);
	ctrlWord_t w;
	w = '0;
	w.pcWrite     = s inside {fetch, jump, jumpReg, exception};
	w.pcWriteCond = s == branch;
	w.branchNe    = s == branch && k == kindBne;
	w.irWrite     = s == irLoad;
	w.aLoad       = s == rTypeLoad;
	w.bLoad       = s == rTypeLoad;
	w.aluSrcA     = s inside {aluExec, immExec, memAddr, branch, jumpReg};
	w.aluOutLoad  = s inside {aluExec, immExec, memAddr};
	w.regWrite    = s inside {aluWriteback, shiftExec, setLess, setLessImm,
		immWriteback, loadWriteback, loadUpper};
	w.regDst      = s inside {aluWriteback, shiftExec, setLess}; // rd targets
	w.iorD        = s inside {loadWait, storeWord};
	w.mdrLoad     = s == loadWait;
	w.memWrite    = s == storeWord;
	w.epcWrite    = s == exception;
	case (s)
		branch:    w.pcSrc = branchTarget;
		jump:      w.pcSrc = jumpTarget;
		exception: w.pcSrc = exceptionVector;
		default:   w.pcSrc = aluResult;
	endcase
	case (s)
		fetch, exception: w.aluSrcB = constFour;
		decode:           w.aluSrcB = shiftedImm;
		immExec, memAddr: w.aluSrcB = signImm;
		default:          w.aluSrcB = regB;
	endcase
	case (s)
		fetch, memAddr:                         w.aluOp = add;
		setLess, setLessImm, branch, exception: w.aluOp = sub;
		aluExec, immExec: begin
			case (k)
				kindSub:           w.aluOp = sub;
				kindAnd, kindAndi: w.aluOp = andOp;
				kindXor, kindXori: w.aluOp = xorOp;
				default:           w.aluOp = add;
			endcase
		end
		default: w.aluOp = pass;
	endcase
	case (s)
		loadWriteback:       w.memToReg = mdr;
		loadUpper:           w.memToReg = upperImm;
		shiftExec:           w.memToReg = shiftOut;
		setLess, setLessImm: w.memToReg = lessThan;
		default:             w.memToReg = aluOut;
	endcase
	if (s == shiftLoad) begin
		w.shiftCtrl = load;
	end else if (s == shiftExec) begin
		w.shiftCtrl = (k inside {kindSll, kindSllv}) ? left :
			(k == kindSrl) ? rightLogic : rightArith;
	end
	return w;
endfunction

task automatic cycleCheck(input string name, input state_t s, input instrKind_t k);
	check($sformatf("%s, state", name), 32'(s), 32'(state));
	check($sformatf("%s, ctrl in %s", name, s.name()), 32'(expectedWord(s, k)), 32'(ctrl));
	@(negedge clock);
endtask

// Entered on a falling edge in fetch; unused tail states are given as fetch
task automatic runInstr(input string name, input logic [`OPCODE_W-1:0] op,
		input logic [`FUNCT_W-1:0] fn, input logic ovf, input instrKind_t k,
		input state_t s1, input state_t s2, input state_t s3);
	state_t path [7];
	int n;
	path = '{fetch, fetchWait, irLoad, decode, s1, s2, s3};
	n = 5;
	if (s2 != fetch) begin
		n = 6;
	end
	if (s3 != fetch) begin
		n = 7;
	end
	opcode   = op;
	funct    = fn;
	overflow = ovf; // Held for the whole instruction
	for (int i = 0; i < n; i++) begin
		cycleCheck(name, path[i], k);
	end
	check($sformatf("%s, back to fetch", name), 32'(fetch), 32'(state));
endtask

task automatic resetAndFetch();
	reset = 1'b1;
	repeat (16) begin
		@(negedge clock);
		check("reset, state", 32'(controlPkg::reset), 32'(state));
		check("reset, ctrl", 32'd0, 32'(ctrl));
	end
	reset = 1'b0;
	@(negedge clock);
	runInstr("fetch and lui", `OP_LUI, '0, 1'b0, kindLui, loadUpper, fetch, fetch);
endtask

task automatic rTypeOps();
	runInstr("add", `OP_RTYPE, `FN_ADD, 1'b0, kindAdd, rTypeLoad, aluExec, aluWriteback);
	runInstr("sub", `OP_RTYPE, `FN_SUB, 1'b0, kindSub, rTypeLoad, aluExec, aluWriteback);
	runInstr("and", `OP_RTYPE, `FN_AND, 1'b0, kindAnd, rTypeLoad, aluExec, aluWriteback);
	runInstr("xor", `OP_RTYPE, `FN_XOR, 1'b0, kindXor, rTypeLoad, aluExec, aluWriteback);
	runInstr("slt", `OP_RTYPE, `FN_SLT, 1'b0, kindSlt, rTypeLoad, setLess, fetch);
	runInstr("sll", `OP_RTYPE, `FN_SLL, 1'b0, kindSll, rTypeLoad, shiftLoad, shiftExec);
	runInstr("srl", `OP_RTYPE, `FN_SRL, 1'b0, kindSrl, rTypeLoad, shiftLoad, shiftExec);
	runInstr("sra", `OP_RTYPE, `FN_SRA, 1'b0, kindSra, rTypeLoad, shiftLoad, shiftExec);
	runInstr("sllv", `OP_RTYPE, `FN_SLLV, 1'b0, kindSllv, rTypeLoad, shiftLoad, shiftExec);
	runInstr("srav", `OP_RTYPE, `FN_SRAV, 1'b0, kindSrav, rTypeLoad, shiftLoad, shiftExec);
	runInstr("unknown funct", `OP_RTYPE, 6'b111111, 1'b0, kindUnknownFunct,
		rTypeLoad, noOp, fetch);
endtask

task automatic overflowTraps();
	runInstr("add overflow", `OP_RTYPE, `FN_ADD, 1'b1, kindAdd, rTypeLoad, aluExec, exception);
	runInstr("sub overflow", `OP_RTYPE, `FN_SUB, 1'b1, kindSub, rTypeLoad, aluExec, exception);
	runInstr("addi overflow", `OP_ADDI, '0, 1'b1, kindAddi, immExec, exception, fetch);
	runInstr("addiu overflow", `OP_ADDIU, '0, 1'b1, kindAddiu, immExec, immWriteback, fetch);
	runInstr("xor overflow", `OP_RTYPE, `FN_XOR, 1'b1, kindXor,
		rTypeLoad, aluExec, aluWriteback);
endtask

task automatic memoryAndImmediates();
	runInstr("lw", `OP_LW, '0, 1'b0, kindLw, memAddr, loadWait, loadWriteback);
	runInstr("sw", `OP_SW, '0, 1'b0, kindSw, memAddr, storeWord, fetch);
	runInstr("addi", `OP_ADDI, '0, 1'b0, kindAddi, immExec, immWriteback, fetch);
	runInstr("addiu", `OP_ADDIU, '0, 1'b0, kindAddiu, immExec, immWriteback, fetch);
	runInstr("andi", `OP_ANDI, '0, 1'b0, kindAndi, immExec, immWriteback, fetch);
	runInstr("slti", `OP_SLTI, '0, 1'b0, kindSlti, setLessImm, fetch, fetch);
	runInstr("xori", `OP_XORI, '0, 1'b0, kindXori, immExec, immWriteback, fetch);
endtask

task automatic controlFlow();
	runInstr("beq", `OP_BEQ, '0, 1'b0, kindBeq, branch, fetch, fetch);
	runInstr("bne", `OP_BNE, '0, 1'b0, kindBne, branch, fetch, fetch);
	runInstr("j", `OP_J, '0, 1'b0, kindJ, jump, fetch, fetch);
	runInstr("lui", `OP_LUI, '0, 1'b0, kindLui, loadUpper, fetch, fetch);
	runInstr("jr", `OP_RTYPE, `FN_JR, 1'b0, kindJr, rTypeLoad, jumpReg, fetch);
endtask

task automatic breakAndReset();
	opcode   = `OP_RTYPE;
	funct    = `FN_BREAK;
	overflow = 1'b0;
	cycleCheck("break", fetch, kindBreak);
	cycleCheck("break", fetchWait, kindBreak);
	cycleCheck("break", irLoad, kindBreak);
	cycleCheck("break", decode, kindBreak);
	cycleCheck("break", rTypeLoad, kindBreak);
	repeat (30) begin
		cycleCheck("break hold", breakHalt, kindBreak);
	end
	reset = 1'b1;
	@(negedge clock);
	check("break reset", 32'(controlPkg::reset), 32'(state));
	reset = 1'b0;
	@(negedge clock);
	check("break restart", 32'(fetch), 32'(state));
endtask

task automatic illegalOpcodes();
	int          seed;
	int          drawn;
	logic [31:0] r;
	logic [5:0]  op;
	seed  = 41;
	drawn = 0;
	while (drawn < 8) begin
		r  = $random(seed);
		op = r[5:0];
		if (!(op inside {`OP_RTYPE, `OP_J, `OP_BEQ, `OP_BNE, `OP_ADDI, `OP_ADDIU,
				`OP_SLTI, `OP_ANDI, `OP_XORI, `OP_LUI, `OP_LW, `OP_SW})) begin
			runInstr($sformatf("illegal opcode %h", op), op, '0, 1'b0, kindIllegal,
				exception, fetch, fetch);
			drawn++;
		end
	end
endtask

// ==== verification/unidadeControleTb.sv ====
`include "control_macros.svh"

module unidadeControleTb import controlPkg::*; ();

	logic                 clock = 1'b0;
	logic                 reset;
	logic                 overflow;
	logic [`OPCODE_W-1:0] opcode;
	logic [`FUNCT_W-1:0]  funct;
	ctrlWord_t            ctrl;
	state_t               state;

	int errors = 0;
	int checks = 0;
	int cycles = 0;

	// Sum of all test lengths in cycles plus 20 percent
	localparam int cycleLimit = (22 + 75 + 33 + 42 + 26 + 37 + 40) * 6 / 5;

	unidadeControle unidadeControle_i (
		.clock    (clock),
		.reset    (reset),
		.overflow (overflow),
		.opcode   (opcode),
		.funct    (funct),
		.ctrl     (ctrl),
		.state    (state)
	);

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	`include "controlTests.svh"

	initial begin
		forever #10 clock = ~clock;
	end

	initial begin
		while (cycles < cycleLimit) begin
			@(posedge clock);
			cycles++;
		end
		$display("Timeout: the tests did not finish within %0d cycles", cycleLimit);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		reset    = 1'b1;
		overflow = 1'b0;
		opcode   = '0;
		funct    = '0;
		resetAndFetch();
		rTypeOps();
		overflowTraps();
		memoryAndImmediates();
		controlFlow();
		breakAndReset();
		illegalOpcodes();
		$display("Errors: %0d of %0d checks", errors, checks);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== unidadeControle.f ====
+incdir+common
+incdir+verification
common/controlPkg.sv
hdl/instrDecoder.sv
hdl/controlSequencer.sv
hdl/controlEncoder.sv
hdl/unidadeControle.sv
verification/unidadeControleTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= unidadeControleTb
FLAGS     ?= --binary --timing --assert
LOG       ?= sim.log
BUILD     ?= obj_dir
FILELIST  ?= unidadeControle.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "No result in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
